//--- src/hub_pkg.sv
/* Memory hub shared definitions */

package hub_pkg;

    // Word store geometry
    localparam int MEM_AW    = 12;              // 4096 words of 16 bits
    localparam int MEM_WORDS = 1 << MEM_AW;

    // Cycles from request seen to ack in the store
    localparam int MEM_LAT = 3;

    // Download header layout
    localparam int HDR_LEN     = 32;            // Header bytes before the payload
    localparam int GAME_ID_POS = 'h18;          // Game identifier byte

    // Word offsets of each client region
    localparam int SND_BASE  = 0;
    localparam int MAIN_BASE = 1024;
    localparam int GFX_BASE  = 2048;

    // Arbiter requesters, lower index wins
    localparam int NREQ     = 4;
    localparam int REQ_LD   = 0;
    localparam int REQ_GFX  = 1;
    localparam int REQ_MAIN = 2;
    localparam int REQ_SND  = 3;

    // Store data word
    typedef logic [15:0] mem_word_t;

endpackage

//--- src/mem_slot.sv
/* Client slot with one-word cache */

module mem_slot import hub_pkg::*; #(
    parameter type payload_t = logic [15:0],
    parameter int  BASE      = 0
) (
    input  logic              clk,
    input  logic              reset,

    // Client side
    input  logic              cs,
    input  logic [MEM_AW:0]   addr,       // In payload units
    output payload_t          data,
    output logic              ok,
    input  logic              we,
    input  payload_t          din,
    input  logic [1:0]        dsn,        // Active low byte mask

    // Arbiter side
    output logic              req,
    output logic [MEM_AW-1:0] req_addr,
    output logic              req_we,
    output mem_word_t         req_wdata,
    output logic [1:0]        req_wmask,
    input  logic              ack,
    input  mem_word_t         rdata
);

    localparam int PW = $bits(payload_t);
    localparam logic [MEM_AW-1:0] BASE_W = MEM_AW'(BASE);

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_DROP} state_t;

    state_t            state;
    logic              valid;
    logic              phase;      // Second half of a 32-bit fill
    logic              wr_hold;    // Write done, wait for cs to drop
    logic              hit;
    logic [MEM_AW:0]   cache_addr;
    logic [MEM_AW:0]   addr_l;
    payload_t          cache_data;
    mem_word_t         low_word;
    logic [MEM_AW-1:0] word_addr;
    logic [31:0]       fill;

    assign hit  = valid && addr == cache_addr;
    assign data = cache_data;

    // Client address to store word
    always_comb begin
        if (PW == 8)
            word_addr = BASE_W + addr[MEM_AW:1];
        else if (PW == 16)
            word_addr = BASE_W + addr[MEM_AW-1:0];
        else
            word_addr = BASE_W + {addr[MEM_AW-2:0], 1'b0};
    end

    // Payload assembly from the returned word
    always_comb begin
        if (PW == 32)
            fill = {rdata, low_word};               // Lower address in the low half
        else if (PW == 16)
            fill = {16'h0, rdata};
        else
            fill = {24'h0, addr_l[0] ? rdata[7:0] : rdata[15:8]};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_IDLE;
            req     <= 1'b0;
            ok      <= 1'b0;
            valid   <= 1'b0;
            phase   <= 1'b0;
            wr_hold <= 1'b0;
        end else begin
            ok <= cs && !we && hit;
            if (!cs) wr_hold <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (cs && we && !wr_hold) begin
                        req   <= 1'b1;
                        valid <= 1'b0;              // Written word may be cached
                        state <= S_REQ;
                    end else if (cs && !we && !hit) begin
                        req   <= 1'b1;
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (ack) begin
                        req   <= 1'b0;
                        state <= S_DROP;
                        if (req_we) begin
                            ok      <= 1'b1;       // One cycle write done pulse
                            wr_hold <= 1'b1;
                        end else if (PW == 32 && !phase) begin
                            phase <= 1'b1;
                        end else begin
                            valid <= 1'b1;
                            phase <= 1'b0;
                        end
                    end
                end
                default: begin
                    if (!ack) state <= phase ? S_REQ : S_IDLE;
                    if (!ack && phase) req <= 1'b1; // Fetch the high half
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            req_addr  <= word_addr;
            addr_l    <= addr;
            req_we    <= we;
            req_wdata <= mem_word_t'(din);
            req_wmask <= ~dsn;
        end else if (state == S_DROP && !ack && phase) begin
            req_addr <= req_addr + 1'b1;
        end
        if (state == S_REQ && ack && !req_we) begin
            if (PW == 32 && !phase) begin
                low_word <= rdata;
            end else begin
                cache_data <= payload_t'(fill[PW-1:0]);
                cache_addr <= addr_l;
            end
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        req && !ack |=> $stable(req_addr));

endmodule

//--- src/slot_arbiter.sv
/* Fixed-priority store arbiter */

module slot_arbiter import hub_pkg::*; (
    input  logic              clk,
    input  logic              reset,

    input  logic [NREQ-1:0]   req,
    output logic [NREQ-1:0]   ack,
    input  logic [MEM_AW-1:0] addr0,
    input  logic [MEM_AW-1:0] addr1,
    input  logic [MEM_AW-1:0] addr2,
    input  logic [MEM_AW-1:0] addr3,
    input  logic              we0,
    input  logic              we1,
    input  logic              we2,
    input  logic              we3,
    input  mem_word_t         wdata0,
    input  mem_word_t         wdata1,
    input  mem_word_t         wdata2,
    input  mem_word_t         wdata3,
    input  logic [1:0]        wmask0,
    input  logic [1:0]        wmask1,
    input  logic [1:0]        wmask2,
    input  logic [1:0]        wmask3,
    output mem_word_t         rdata,

    // Store side
    output logic              mem_req,
    output logic [MEM_AW-1:0] mem_addr,
    output logic              mem_we,
    output mem_word_t         mem_wdata,
    output logic [1:0]        mem_wmask,
    input  logic              mem_ack,
    input  mem_word_t         mem_rdata
);

    localparam int SW = $clog2(NREQ);

    typedef enum logic [1:0] {A_IDLE, A_MEM, A_ACK} state_t;

    state_t            state;
    logic [SW-1:0]     win, sel;
    logic [MEM_AW-1:0] c_addr;
    logic              c_we;
    mem_word_t         c_wdata;
    logic [1:0]        c_wmask;

    // Lowest active index
    always_comb begin
        win = '0;
        for (int i = NREQ - 1; i >= 0; i--)
            if (req[i]) win = SW'(i);
    end

    always_comb begin
        case (win)
            2'd0:    {c_addr, c_we, c_wdata, c_wmask} = {addr0, we0, wdata0, wmask0};
            2'd1:    {c_addr, c_we, c_wdata, c_wmask} = {addr1, we1, wdata1, wmask1};
            2'd2:    {c_addr, c_we, c_wdata, c_wmask} = {addr2, we2, wdata2, wmask2};
            default: {c_addr, c_we, c_wdata, c_wmask} = {addr3, we3, wdata3, wmask3};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= A_IDLE;
            sel     <= '0;
            ack     <= '0;
            mem_req <= 1'b0;
        end else begin
            case (state)
                A_IDLE: if (|req && !mem_ack) begin // Store fully idle
                    sel     <= win;
                    mem_req <= 1'b1;
                    state   <= A_MEM;
                end
                A_MEM: if (mem_ack) begin
                    mem_req  <= 1'b0;
                    ack[sel] <= 1'b1;
                    state    <= A_ACK;
                end
                default: if (!req[sel]) begin
                    ack   <= '0;
                    state <= A_IDLE;
                end
            endcase
        end
    end

    // Command and read data
    always_ff @(posedge clk) begin
        if (state == A_IDLE) {mem_addr, mem_we, mem_wdata, mem_wmask} <=
            {c_addr, c_we, c_wdata, c_wmask};
        if (state == A_MEM && mem_ack) rdata <= mem_rdata;
    end

    a_one_ack: assert property (@(posedge clk) disable iff (reset) $onehot0(ack));
    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ack |=> mem_req);

endmodule

//--- src/word_store.sv
/* Fixed latency word memory */

module word_store import hub_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_req,
    input  logic [MEM_AW-1:0] mem_addr,
    input  logic              mem_we,
    input  mem_word_t         mem_wdata,
    input  logic [1:0]        mem_wmask,   // Bit 1 high byte, bit 0 low byte
    output logic              mem_ack,
    output mem_word_t         mem_rdata
);

    localparam int CW = $clog2(MEM_LAT + 1);

    mem_word_t   mem [0:MEM_WORDS-1];
    logic [CW-1:0] cnt;
    logic        fire;

    // Last latency cycle of a pending request
    assign fire = mem_req && !mem_ack && cnt == CW'(MEM_LAT - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt     <= '0;
            mem_ack <= 1'b0;
        end else if (mem_ack) begin
            if (!mem_req) mem_ack <= 1'b0;   // Hold ack until req falls
        end else if (fire) begin
            cnt     <= '0;
            mem_ack <= 1'b1;
        end else if (mem_req) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            if (mem_we) begin
                if (mem_wmask[1]) mem[mem_addr][15:8] <= mem_wdata[15:8];
                if (mem_wmask[0]) mem[mem_addr][7:0]  <= mem_wdata[7:0];
            end else begin
                mem_rdata <= mem[mem_addr];
            end
        end
    end

    a_ack_window: assert property (@(posedge clk) disable iff (reset)
        mem_ack |-> (mem_req || $past(mem_req)));

endmodule

//--- src/rom_loader.sv
/* Download stream to word writes */

module rom_loader import hub_pkg::*; (
    input  logic              clk,
    input  logic              reset,

    // Download stream
    input  logic              downloading,
    input  logic [15:0]       ioctl_addr,
    input  logic [7:0]        ioctl_data,
    input  logic              ioctl_wr,
    output logic [7:0]        game_id,
    output logic              dwnld_busy,

    // Arbiter side
    output logic              req,
    output logic [MEM_AW-1:0] req_addr,
    output logic              req_we,
    output mem_word_t         req_wdata,
    output logic [1:0]        req_wmask,
    input  logic              ack
);

    logic        header;
    logic        take;
    logic [15:0] pay_off;
    logic [7:0]  hi_byte;

    assign take    = downloading && ioctl_wr;
    assign header  = ioctl_addr < 16'(HDR_LEN);
    assign pay_off = ioctl_addr - 16'(HDR_LEN);   // Byte offset inside the payload

    // Loader only writes full words
    assign req_we    = 1'b1;
    assign req_wmask = 2'b11;

    always_ff @(posedge clk) begin
        if (take && header && ioctl_addr == 16'(GAME_ID_POS))
            game_id <= ioctl_data;
    end

    // Even byte is the high half
    always_ff @(posedge clk) begin
        if (take && !header) begin
            if (!pay_off[0]) begin
                hi_byte <= ioctl_data;
            end else begin
                req_wdata <= {hi_byte, ioctl_data};
                req_addr  <= pay_off[MEM_AW:1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req        <= 1'b0;
            dwnld_busy <= 1'b0;
        end else if (take && !header && pay_off[0] && !dwnld_busy) begin
            req        <= 1'b1;
            dwnld_busy <= 1'b1;
        end else if (req && ack) begin
            req <= 1'b0;
        end else if (dwnld_busy && !req && !ack) begin
            dwnld_busy <= 1'b0;                  // Handshake closed
        end
    end

endmodule

//--- src/mem_hub_top.sv
/* Memory hub top level */

module mem_hub_top import hub_pkg::*; (
    input  logic            clk,
    input  logic            reset,

    // ROM download
    input  logic            downloading,
    input  logic [15:0]     ioctl_addr,
    input  logic [7:0]      ioctl_data,
    input  logic            ioctl_wr,
    output logic [7:0]      game_id,
    output logic            dwnld_busy,

    // Sound CPU
    input  logic            snd_cs,
    input  logic [MEM_AW:0] snd_addr,
    output logic [7:0]      snd_data,
    output logic            snd_ok,

    // Main CPU
    input  logic            main_cs,
    input  logic [MEM_AW:0] main_addr,
    output logic [15:0]     main_data,
    output logic            main_ok,
    input  logic            main_we,
    input  logic [15:0]     main_din,
    input  logic [1:0]      main_dsn,

    // Graphics
    input  logic            gfx_cs,
    input  logic [MEM_AW:0] gfx_addr,
    output logic [31:0]     gfx_data,
    output logic            gfx_ok
);

    logic [NREQ-1:0]   arb_ack;
    mem_word_t         arb_rdata;
    logic              ld_req, snd_req, main_req, gfx_req;
    logic [MEM_AW-1:0] ld_addr, snd_raddr, main_raddr, gfx_raddr;
    logic              ld_we, snd_we, main_rwe, gfx_we;
    mem_word_t         ld_wdata, snd_wdata, main_wdata, gfx_wdata;
    logic [1:0]        ld_wmask, snd_wmask, main_wmask, gfx_wmask;

    logic              mem_req, mem_we, mem_ack;
    logic [MEM_AW-1:0] mem_addr;
    mem_word_t         mem_wdata, mem_rdata;
    logic [1:0]        mem_wmask;

    mem_slot #(.payload_t(logic [7:0]), .BASE(SND_BASE)) u_snd (
        .clk(clk), .reset(reset),
        .cs(snd_cs), .addr(snd_addr), .data(snd_data), .ok(snd_ok),
        .we(1'b0), .din(8'h00), .dsn(2'b11),        // Read only
        .req(snd_req), .req_addr(snd_raddr), .req_we(snd_we),
        .req_wdata(snd_wdata), .req_wmask(snd_wmask),
        .ack(arb_ack[REQ_SND]), .rdata(arb_rdata)
    );

    mem_slot #(.payload_t(logic [15:0]), .BASE(MAIN_BASE)) u_main (
        .clk(clk), .reset(reset),
        .cs(main_cs), .addr(main_addr), .data(main_data), .ok(main_ok),
        .we(main_we), .din(main_din), .dsn(main_dsn),
        .req(main_req), .req_addr(main_raddr), .req_we(main_rwe),
        .req_wdata(main_wdata), .req_wmask(main_wmask),
        .ack(arb_ack[REQ_MAIN]), .rdata(arb_rdata)
    );

    mem_slot #(.payload_t(logic [31:0]), .BASE(GFX_BASE)) u_gfx (
        .clk(clk), .reset(reset),
        .cs(gfx_cs), .addr(gfx_addr), .data(gfx_data), .ok(gfx_ok),
        .we(1'b0), .din(32'h0), .dsn(2'b11),         // Read only
        .req(gfx_req), .req_addr(gfx_raddr), .req_we(gfx_we),
        .req_wdata(gfx_wdata), .req_wmask(gfx_wmask),
        .ack(arb_ack[REQ_GFX]), .rdata(arb_rdata)
    );

    rom_loader u_loader (
        .clk(clk), .reset(reset),
        .downloading(downloading), .ioctl_addr(ioctl_addr),
        .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr),
        .game_id(game_id), .dwnld_busy(dwnld_busy),
        .req(ld_req), .req_addr(ld_addr), .req_we(ld_we),
        .req_wdata(ld_wdata), .req_wmask(ld_wmask), .ack(arb_ack[REQ_LD])
    );

    slot_arbiter u_arb (
        .clk(clk), .reset(reset),
        .req({snd_req, main_req, gfx_req, ld_req}), .ack(arb_ack),
        .addr0(ld_addr), .addr1(gfx_raddr), .addr2(main_raddr), .addr3(snd_raddr),
        .we0(ld_we), .we1(gfx_we), .we2(main_rwe), .we3(snd_we),
        .wdata0(ld_wdata), .wdata1(gfx_wdata), .wdata2(main_wdata), .wdata3(snd_wdata),
        .wmask0(ld_wmask), .wmask1(gfx_wmask), .wmask2(main_wmask), .wmask3(snd_wmask),
        .rdata(arb_rdata),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_we(mem_we),
        .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    word_store u_store (
        .clk(clk), .reset(reset),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_we(mem_we),
        .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

endmodule

//--- verification/mem_hub_checker.sv
/* Memory hub response checker */

module mem_hub_checker import hub_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            downloading,
    input  logic            ioctl_wr,
    input  logic [15:0]     ioctl_addr,
    input  logic [7:0]      ioctl_data,
    input  logic [7:0]      game_id,
    input  logic            dwnld_busy,
    input  logic            snd_cs, snd_ok,
    input  logic [MEM_AW:0] snd_addr,
    input  logic [7:0]      snd_data,
    input  logic            main_cs, main_ok, main_we,
    input  logic [MEM_AW:0] main_addr,
    input  logic [15:0]     main_data, main_din,
    input  logic [1:0]      main_dsn,
    input  logic            gfx_cs, gfx_ok,
    input  logic [MEM_AW:0] gfx_addr,
    input  logic [31:0]     gfx_data,
    input  logic            exp_on,
    input  logic [15:0]     exp_main,
    output int              checks,
    output int              errors
);

    localparam int OK_WAIT = 150;       // Longest fair wait for ok

    logic [15:0]       image [0:MEM_WORDS-1];   // Reference copy of the store
    logic [7:0]        hi_byte, hdr_game;
    logic              dl_q;
    logic [MEM_AW-1:0] w;
    int                pay, busy_left, snd_wait, main_wait, gfx_wait;

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic count_wait(input logic cs, input string name, inout int n);
        n = cs ? n + 1 : 0;
        if (n == OK_WAIT) begin
            errors++;
            $display("%s client held cs for %0d cycles and never got ok", name, OK_WAIT);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            checks    = 0;
            errors    = 0;
            dl_q      = 1'b0;
            busy_left = 0;
            snd_wait  = 0;
            main_wait = 0;
            gfx_wait  = 0;
        end else begin
            // Busy must cover the loader write up to its ack
            if (busy_left > 0) begin
                compare("dwnld_busy", 32'd1, 32'(dwnld_busy));
                busy_left--;
            end
            if (downloading && ioctl_wr) begin
                pay = int'(ioctl_addr) - HDR_LEN;
                if (pay < 0) begin
                    if (ioctl_addr == 16'(GAME_ID_POS))
                        hdr_game = ioctl_data;
                end else if (pay % 2 == 0) begin
                    hi_byte = ioctl_data;               // Even byte is the high half
                end else begin
                    w = MEM_AW'(pay / 2);
                    image[w] = {hi_byte, ioctl_data};
                    busy_left = MEM_LAT + 2;            // Grant, store latency, ack
                end
            end
            if (dl_q && !downloading)
                compare("game_id", 32'(hdr_game), 32'(game_id));
            dl_q = downloading;

            if (snd_ok) begin
                w = MEM_AW'(SND_BASE + int'(snd_addr) / 2);
                compare("snd_data", 32'(snd_addr[0] ? image[w][7:0] : image[w][15:8]),
                    32'(snd_data));
            end
            if (main_ok) begin
                w = MEM_AW'(MAIN_BASE + int'(main_addr));
                if (main_we) begin
                    if (!main_dsn[1]) image[w][15:8] = main_din[15:8];
                    if (!main_dsn[0]) image[w][7:0] = main_din[7:0];
                end else begin
                    compare("main_data", 32'(image[w]), 32'(main_data));
                    if (exp_on)
                        compare("main_data", 32'(exp_main), 32'(main_data));
                end
            end
            if (gfx_ok) begin
                w = MEM_AW'(GFX_BASE + 2 * int'(gfx_addr));
                compare("gfx_data", {image[w + 1'b1], image[w]}, gfx_data);
            end

            count_wait(snd_cs, "sound", snd_wait);
            count_wait(main_cs, "main", main_wait);
            count_wait(gfx_cs, "graphics", gfx_wait);
        end
    end

endmodule

//--- verification/mem_hub_tb.sv
/* Memory hub testbench */

module mem_hub_tb import hub_pkg::*; ();

    typedef struct packed {
        logic [1:0]      client;      // 0 sound, 1 main, 2 graphics
        logic            with_next;   // Issued together with the next entry
        logic [MEM_AW:0] addr;
        logic            we;
        logic [15:0]     din;
        logic [1:0]      dsn;
        logic            exp_on;      // Fixed expected main value
        logic [15:0]     exp;
    } access_t;

    localparam int NUM_ACC   = 20;
    localparam int NUM_BYTES = HDR_LEN + 2 * (8 + 8 + 16);
    localparam int LIMIT     = 40 * NUM_ACC + 20 * NUM_BYTES + 100;

    logic            clk, reset;
    logic            downloading, ioctl_wr, dwnld_busy;
    logic [15:0]     ioctl_addr;
    logic [7:0]      ioctl_data, game_id;
    logic            snd_cs, snd_ok, main_cs, main_ok, main_we, gfx_cs, gfx_ok;
    logic [MEM_AW:0] snd_addr, main_addr, gfx_addr;
    logic [7:0]      snd_data;
    logic [15:0]     main_data, main_din;
    logic [31:0]     gfx_data;
    logic [1:0]      main_dsn;
    logic            exp_on;
    logic [15:0]     exp_main;
    logic [31:0]     lcg;
    int              checks, errors;
    int              cycles = 0;
    access_t         accesses [NUM_ACC];

    mem_hub_top UUT (.*);

    mem_hub_checker u_check (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == LIMIT) begin
            $display("timeout after %0d cycles, the run did not complete", cycles);
            end_run(1'b1);
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic end_run(input logic timed_out);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !timed_out)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    endtask

    task automatic send_byte(input logic [15:0] a, input logic [7:0] d);
        @(negedge clk);
        while (dwnld_busy) @(negedge clk);   // Back-pressure from the loader
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr   = 1'b0;
    endtask

    // Random payload for a run of store words
    task automatic load_words(input int first, input int count);
        for (int w = first; w < first + count; w++) begin
            for (int k = 0; k < 2; k++) begin
                lcg = lcg_next(lcg);
                send_byte(16'(HDR_LEN + 2 * w + k), lcg[23:16]);
            end
        end
    endtask

    task automatic launch_access(input access_t a);
        if (a.client == 2'd0) begin
            snd_addr = a.addr;
            snd_cs   = 1'b1;
        end else if (a.client == 2'd1) begin
            main_addr = a.addr;
            main_we   = a.we;
            main_din  = a.din;
            main_dsn  = a.dsn;
            exp_on    = a.exp_on;
            exp_main  = a.exp;
            main_cs   = 1'b1;
        end else begin
            gfx_addr = a.addr;
            gfx_cs   = 1'b1;
        end
    endtask

    initial begin
        logic [4:0] n;
        logic [2:0] pending;

        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        main_cs     = 1'b0;
        main_addr   = '0;
        main_we     = 1'b0;
        main_din    = '0;
        main_dsn    = 2'b11;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        exp_on      = 1'b0;
        exp_main    = '0;
        lcg         = 32'h5c4b_f1de;
        accesses = '{
            '{2'd0, 1'b0, 13'd4, 1'b0, 16'h0000, 2'b11, 1'b0, 16'h0000},  // High byte
            '{2'd0, 1'b0, 13'd5, 1'b0, 16'h0000, 2'b11, 1'b0, 16'h0000},  // Low byte
            '{2'd0, 1'b0, 13'd5, 1'b0, 16'h0000, 2'b11, 1'b0, 16'h0000},
            '{2'd1, 1'b0, 13'd0, 1'b0, 16'h0000, 2'b11, 1'b0, 16'h0000},
            '{2'd1, 1'b0, 13'd3, 1'b0, 16'h0000, 2'b11, 1'b0, 16'h0000},
            '{2'd1, 1'b0, 13'd3, 1'b0, 16'h0000, 2'b11, 1'b0, 16'h0000},  // Cache hit
            '{2'd1, 1'b0, 13'd3, 1'b1, 16'h5aa5, 2'b10, 1'b0, 16'h0000},  // Low byte only
            '{2'd1, 1'b0, 13'd3, 1'b0, 16'h0000, 2'b11, 1'b0, 16'h0000},
            '{2'd1, 1'b0, 13'd6, 1'b1, 16'hbeef, 2'b00, 1'b0, 16'h0000},
            '{2'd1, 1'b0, 13'd6, 1'b0, 16'h0000, 2'b11, 1'b1, 16'hbeef},
            '{2'd2, 1'b0, 13'd1, 1'b0, 16'h0000, 2'b11, 1'b0, 16'h0000},
            '{2'd2, 1'b0, 13'd1, 1'b0, 16'h0000, 2'b11, 1'b0, 16'h0000},
            '{2'd2, 1'b0, 13'd5, 1'b0, 16'h0000, 2'b11, 1'b0, 16'h0000},
            '{2'd0, 1'b1, 13'd14, 1'b0, 16'h0000, 2'b11, 1'b0, 16'h0000}, // All three at once
            '{2'd1, 1'b1, 13'd7, 1'b0, 16'h0000, 2'b11, 1'b0, 16'h0000},
            '{2'd2, 1'b0, 13'd7, 1'b0, 16'h0000, 2'b11, 1'b0, 16'h0000},
            '{2'd0, 1'b1, 13'd1, 1'b0, 16'h0000, 2'b11, 1'b0, 16'h0000},
            '{2'd1, 1'b1, 13'd6, 1'b1, 16'h1234, 2'b01, 1'b0, 16'h0000},  // High byte only
            '{2'd2, 1'b0, 13'd2, 1'b0, 16'h0000, 2'b11, 1'b0, 16'h0000},
            '{2'd1, 1'b0, 13'd6, 1'b0, 16'h0000, 2'b11, 1'b1, 16'h12ef}
        };
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Download phase
        downloading = 1'b1;
        for (int i = 0; i < HDR_LEN; i++) begin
            lcg = lcg_next(lcg);
            send_byte(16'(i), lcg[23:16]);
        end
        load_words(SND_BASE, 8);
        load_words(MAIN_BASE, 8);
        load_words(GFX_BASE, 16);
        @(negedge clk);
        while (dwnld_busy) @(negedge clk);   // Last word still in flight
        downloading = 1'b0;
        repeat (2) @(negedge clk);

        // Client accesses, grouped entries start on the same edge
        n = '0;
        while (n < 5'(NUM_ACC)) begin
            @(negedge clk);
            pending = '0;
            do begin
                launch_access(accesses[n]);
                pending[accesses[n].client] = 1'b1;
                n = n + 1'b1;
            end while (accesses[n - 1'b1].with_next && n < 5'(NUM_ACC));
            while (pending != 3'b000) begin
                @(negedge clk);
                if (pending[0] && snd_ok) begin
                    snd_cs     = 1'b0;
                    pending[0] = 1'b0;
                end
                if (pending[1] && main_ok) begin
                    main_cs    = 1'b0;
                    pending[1] = 1'b0;
                end
                if (pending[2] && gfx_ok) begin
                    gfx_cs     = 1'b0;
                    pending[2] = 1'b0;
                end
            end
        end
        repeat (4) @(negedge clk);
        end_run(1'b0);
    end

endmodule

//--- vlog.f
src/hub_pkg.sv
src/mem_slot.sv
src/slot_arbiter.sv
src/word_store.sv
src/rom_loader.sv
src/mem_hub_top.sv
verification/mem_hub_checker.sv
verification/mem_hub_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory hub testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module mem_hub_tb \
    -o mem_hub_sim

./obj_dir/mem_hub_sim | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failures"
